// ==== soc_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared sizes, bus-cycle and block-port enums
// imported by every module of the subsystem
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package soc_pkg;

   // memory geometry
   localparam int ram_addr_w = 16;
   localparam int vram_addr_w = 14;

   // one sector of the block device
   localparam int sector_bytes = 512;

   // reset stretch after the last reset source falls
   localparam int reset_hold_cycles = 256;

   // block port lives at i/o 0..7, only bits 7:3 are compared
   localparam logic [7:0] io_block_base = 8'h00;

   // osd status: bit 0 is power-up reset, bit 2 is the menu reset entry
   localparam logic [7:0] status_reset_bits = 8'b0000_0101;

   // flops in front of the vsync edge detector
   localparam int irq_sync_stages = 2;

   // decoded processor bus cycle
   typedef enum logic [2:0] {
      op_idle,
      op_mem_rd,
      op_ram_wr,
      op_vram_wr,
      op_io_rd,
      op_io_wr,
      op_int_ack
   } bus_op_t;

   // block port register offsets, low three i/o address bits
   typedef enum logic [2:0] {
      reg_data = 3'd0,
      reg_cmd  = 3'd1,
      reg_lba0 = 3'd4,
      reg_lba1 = 3'd5,
      reg_lba2 = 3'd6,
      reg_lba3 = 3'd7
   } blk_reg_t;

   // command byte written to reg_cmd
   typedef enum logic [7:0] {
      cmd_none  = 8'd0,
      cmd_read  = 8'd1,
      cmd_write = 8'd2
   } blk_cmd_t;

   typedef enum logic [1:0] {
      blk_idle,
      blk_reading,
      blk_writing
   } blk_state_t;

endpackage

// ==== soc_bus_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus cycle decode, read data mux and reset stretch
// one datapath strobe per cycle, read data one cycle later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module soc_bus_ctrl
   import soc_pkg::*;
(
   input  logic                  cpu_clock,
   input  logic                  cpu_reset,
   input  logic [7:0]            osd_status,
   input  logic                  dio_download,
   input  logic [ram_addr_w-1:0] cpu_addr,
   input  logic                  cpu_mreq,
   input  logic                  cpu_iorq,
   input  logic                  cpu_rd,
   input  logic                  cpu_wr,
   input  logic                  cpu_m1,
   output logic [7:0]            cpu_din,
   output logic                  core_reset,
   output logic                  ram_rd,
   output logic                  ram_wr,
   output logic                  vram_wr,
   output logic                  blk_rd,
   output logic                  blk_wr,
   output logic [2:0]            blk_addr,
   output logic                  int_ack,
   input  logic [7:0]            ram_q,
   input  logic [7:0]            blk_q
);

   localparam int cnt_w = $clog2(reset_hold_cycles);
   localparam logic [cnt_w-1:0] cnt_last = cnt_w'(reset_hold_cycles - 1);

   bus_op_t          op;
   bus_op_t          rd_op_q;
   logic             io_sel;
   logic             io_rd_cycle;
   logic             hold;
   logic [cnt_w-1:0] hold_cnt;

   // block port page match on the low address byte
   assign io_sel = cpu_addr[7:3] == io_block_base[7:3];
   // any i/o read, mapped or not, selects the next cpu_din source
   assign io_rd_cycle = !dio_download && cpu_iorq && cpu_rd && !cpu_m1;

   // classify the cycle, download mutes the processor completely
   always_comb begin
      op = op_idle;
      if (!dio_download) begin
         if (cpu_mreq && cpu_wr) begin
            // a15 picks main ram, low half goes to video ram
            op = cpu_addr[ram_addr_w-1] ? op_ram_wr : op_vram_wr;
         end else if (cpu_mreq && (cpu_rd || cpu_m1)) begin
            op = op_mem_rd;
         end else if (cpu_iorq && cpu_m1) begin
            op = op_int_ack;
         end else if (cpu_iorq && io_sel && cpu_rd) begin
            op = op_io_rd;
         end else if (cpu_iorq && io_sel && cpu_wr) begin
            op = op_io_wr;
         end
      end
   end

   assign ram_rd   = op == op_mem_rd;
   assign ram_wr   = op == op_ram_wr;
   assign vram_wr  = op == op_vram_wr;
   assign blk_rd   = op == op_io_rd;
   assign blk_wr   = op == op_io_wr;
   assign int_ack  = op == op_int_ack;
   assign blk_addr = cpu_addr[2:0];

   // remember where the last read went, unmapped i/o stays op_idle
   always_ff @(posedge cpu_clock) begin
      if (cpu_reset) begin
         rd_op_q <= op_idle;
      end else if (ram_rd || io_rd_cycle) begin
         rd_op_q <= op;
      end
   end

   // source registers only reload on their own strobe, so this holds
   always_comb begin
      case (rd_op_q)
         op_mem_rd: cpu_din = ram_q;
         op_io_rd:  cpu_din = blk_q;
         default:   cpu_din = 8'h00;
      endcase
   end

   assign hold = cpu_reset || dio_download || |(osd_status & status_reset_bits);

   // counter restarts on every reset source
   // registered output adds the last cycle of the stretch
   always_ff @(posedge cpu_clock) begin
      if (hold) begin
         hold_cnt   <= '0;
         core_reset <= 1'b1;
      end else begin
         if (hold_cnt != cnt_last) begin
            hold_cnt <= hold_cnt + 1'b1;
         end
         core_reset <= hold_cnt != cnt_last;
      end
   end

   // datapath blocks each assume they own the cycle
   a_one_strobe: assert property (@(posedge cpu_clock) disable iff (cpu_reset)
      $onehot0({ram_rd, ram_wr, vram_wr, blk_rd, blk_wr, int_ack}))
      else $error("more than one datapath strobe in a cycle");

endmodule

// ==== soc_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 64 KiB main memory, processor port plus rom download port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module soc_ram
   import soc_pkg::*;
(
   input  logic                  cpu_clock,
   input  logic                  ram_rd,
   input  logic                  ram_wr,
   input  logic [ram_addr_w-1:0] cpu_addr,
   input  logic [7:0]            cpu_dout,
   input  logic                  dio_download,
   input  logic                  dio_write,
   input  logic [ram_addr_w-1:0] dio_addr,
   input  logic [7:0]            dio_data,
   output logic [7:0]            ram_q
);

   logic [7:0] mem [0:2**ram_addr_w-1];
   bus_op_t    ram_op;

   // rebuild the bus view of this port from its strobes
   assign ram_op = ram_wr ? op_ram_wr : (ram_rd ? op_mem_rd : op_idle);

   // download owns the write port while it runs
   always_ff @(posedge cpu_clock) begin
      if (dio_download) begin
         if (dio_write) begin
            mem[dio_addr] <= dio_data;
         end
      end else if (ram_op == op_ram_wr) begin
         mem[cpu_addr] <= cpu_dout;
      end
   end

   // read register only loads on a read strobe
   // so cpu_din keeps the byte until the next read
   always_ff @(posedge cpu_clock) begin
      if (ram_op == op_mem_rd) begin
         ram_q <= mem[cpu_addr];
      end
   end

   // the decoder must keep the processor off the array during a download,
   // and the rom half below 8000h is never written by the processor
   a_wr_owner: assert property (@(posedge cpu_clock)
      (ram_op == op_ram_wr) |-> (!dio_download && cpu_addr[ram_addr_w-1]))
      else $error("processor ram write during download or into rom half");

endmodule

// ==== video_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16 KiB video memory, processor writes and registered video reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module video_ram
   import soc_pkg::*;
(
   input  logic                   cpu_clock,
   input  logic                   vram_wr,
   input  logic [ram_addr_w-1:0]  cpu_addr,
   input  logic [7:0]             cpu_dout,
   input  logic [vram_addr_w-1:0] video_addr,
   output logic [7:0]             video_q
);

   logic [7:0]             mem [0:2**vram_addr_w-1];
   logic [vram_addr_w-1:0] wr_addr;

   // processor side folds the lower 32 KiB onto 16 KiB
   assign wr_addr = cpu_addr[vram_addr_w-1:0];

   always_ff @(posedge cpu_clock) begin
      if (vram_wr) begin
         mem[wr_addr] <= cpu_dout;
      end
   end

   // video side reads every cycle
   // one cycle latency, no enable
   always_ff @(posedge cpu_clock) begin
      video_q <= mem[video_addr];
   end

endmodule

// ==== block_io.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// block device port at i/o 0..7, sector buffer and command FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module block_io
   import soc_pkg::*;
(
   input  logic        cpu_clock,
   input  logic        core_reset,
   input  logic        blk_rd,
   input  logic        blk_wr,
   input  logic [2:0]  blk_addr,
   input  logic [7:0]  cpu_dout,
   output logic [7:0]  blk_q,
   output logic [31:0] io_lba,
   output logic        io_rd,
   output logic        io_wr,
   output logic [7:0]  io_dout,
   input  logic        io_ack,
   input  logic [7:0]  io_din,
   input  logic        io_din_strobe,
   input  logic        io_dout_strobe
);

   localparam int ptr_w = $clog2(sector_bytes);

   logic [7:0]       buffer [0:sector_bytes-1];
   logic [ptr_w-1:0] cpu_ptr;
   logic [ptr_w-1:0] io_ptr;
   blk_state_t       state;
   blk_reg_t         reg_sel;
   bus_op_t          blk_op;
   logic             busy;
   logic             data_rd;
   logic             data_wr;
   logic             cmd_start;
   logic             io_step;

   assign reg_sel = blk_reg_t'(blk_addr);
   assign blk_op  = blk_wr ? op_io_wr : (blk_rd ? op_io_rd : op_idle);
   assign busy    = state != blk_idle;

   // processor accesses to the data register move cpu_ptr
   assign data_rd = blk_op == op_io_rd && reg_sel == reg_data;
   assign data_wr = blk_op == op_io_wr && reg_sel == reg_data;

   // only read and write commands start, and never while busy
   assign cmd_start = blk_op == op_io_wr && reg_sel == reg_cmd && !busy &&
                      (cpu_dout == cmd_read || cpu_dout == cmd_write);

   // request levels come straight from the state
   assign io_rd = state == blk_reading;
   assign io_wr = state == blk_writing;

   // controller pointer steps on the strobe of the running direction
   assign io_step = (io_din_strobe && io_rd) || (io_dout_strobe && io_wr);

   // outgoing byte always tracks the controller pointer
   assign io_dout = buffer[io_ptr];

   always_ff @(posedge cpu_clock) begin
      if (core_reset) begin
         state <= blk_idle;
      end else if (io_ack) begin
         state <= blk_idle;
      end else if (cmd_start) begin
         state <= (cpu_dout == cmd_read) ? blk_reading : blk_writing;
      end
   end

   always_ff @(posedge cpu_clock) begin
      if (core_reset) begin
         cpu_ptr <= '0;
         io_ptr  <= '0;
      end else begin
         // ack hands the sector back to the processor from byte 0
         if (io_ack) begin
            cpu_ptr <= '0;
         end else if (data_rd || data_wr) begin
            cpu_ptr <= cpu_ptr + 1'b1;
         end
         if (cmd_start) begin
            io_ptr <= '0;
         end else if (io_step) begin
            io_ptr <= io_ptr + 1'b1;
         end
      end
   end

   // single write port, the controller wins during a sector read
   always_ff @(posedge cpu_clock) begin
      if (io_din_strobe && io_rd) begin
         buffer[io_ptr] <= io_din;
      end else if (data_wr) begin
         buffer[cpu_ptr] <= cpu_dout;
      end
   end

   // lba bytes, little endian
   always_ff @(posedge cpu_clock) begin
      if (blk_op == op_io_wr) begin
         case (reg_sel)
            reg_lba0: io_lba[7:0]   <= cpu_dout;
            reg_lba1: io_lba[15:8]  <= cpu_dout;
            reg_lba2: io_lba[23:16] <= cpu_dout;
            reg_lba3: io_lba[31:24] <= cpu_dout;
            default: ;
         endcase
      end
   end

   // registered read mux, loads only on a read strobe
   always_ff @(posedge cpu_clock) begin
      if (blk_op == op_io_rd) begin
         case (reg_sel)
            reg_data: blk_q <= buffer[cpu_ptr];
            reg_cmd:  blk_q <= {7'd0, busy};
            reg_lba0: blk_q <= io_lba[7:0];
            reg_lba1: blk_q <= io_lba[15:8];
            reg_lba2: blk_q <= io_lba[23:16];
            reg_lba3: blk_q <= io_lba[31:24];
            default:  blk_q <= 8'h00;
         endcase
      end
   end

   a_one_dir: assert property (@(posedge cpu_clock) disable iff (core_reset)
      !(io_rd && io_wr))
      else $error("io_rd and io_wr high together");

   // controller may only push bytes into a running read
   a_din_in_read: assert property (@(posedge cpu_clock) disable iff (core_reset)
      io_din_strobe |-> state == blk_reading)
      else $error("io_din_strobe outside a sector read");

   // processor data writes would be dropped against a controller byte
   a_buf_port: assert property (@(posedge cpu_clock) disable iff (core_reset)
      data_wr |-> !io_din_strobe)
      else $error("processor data write collides with io_din_strobe");

endmodule

// ==== vsync_irq.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vsync interrupt, set on the rising edge, cleared by int ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vsync_irq
   import soc_pkg::*;
(
   input  logic cpu_clock,
   input  logic core_reset,
   input  logic video_vs,
   input  logic int_ack,
   output logic cpu_irq
);

   // sync stages plus one flop of history for the edge
   logic [irq_sync_stages:0] vs_pipe;
   logic                     vs_rise;

   always_ff @(posedge cpu_clock) begin
      if (core_reset) begin
         vs_pipe <= '0;
      end else begin
         vs_pipe <= {vs_pipe[irq_sync_stages-1:0], video_vs};
      end
   end

   assign vs_rise = vs_pipe[irq_sync_stages-1] && !vs_pipe[irq_sync_stages];

   // held until acknowledged, ack beats a same-cycle edge
   always_ff @(posedge cpu_clock) begin
      if (core_reset) begin
         cpu_irq <= 1'b0;
      end else if (int_ack) begin
         cpu_irq <= 1'b0;
      end else if (vs_rise) begin
         cpu_irq <= 1'b1;
      end
   end

endmodule

// ==== soc_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus and peripheral subsystem top, driven by a z80-style bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module soc_core
   import soc_pkg::*;
(
   input  logic                   cpu_clock,
   input  logic                   cpu_reset,
   input  logic [7:0]             osd_status,
   input  logic [ram_addr_w-1:0]  cpu_addr,
   input  logic [7:0]             cpu_dout,
   input  logic                   cpu_mreq,
   input  logic                   cpu_iorq,
   input  logic                   cpu_rd,
   input  logic                   cpu_wr,
   input  logic                   cpu_m1,
   output logic [7:0]             cpu_din,
   output logic                   core_reset,
   output logic                   cpu_irq,
   input  logic                   dio_download,
   input  logic                   dio_write,
   input  logic [ram_addr_w-1:0]  dio_addr,
   input  logic [7:0]             dio_data,
   input  logic                   video_vs,
   input  logic [vram_addr_w-1:0] video_addr,
   output logic [7:0]             video_q,
   output logic [31:0]            io_lba,
   output logic                   io_rd,
   output logic                   io_wr,
   input  logic                   io_ack,
   input  logic [7:0]             io_din,
   input  logic                   io_din_strobe,
   input  logic                   io_dout_strobe,
   output logic [7:0]             io_dout
);

   // strobes from the decoder
   logic       ram_rd;
   logic       ram_wr;
   logic       vram_wr;
   logic       blk_rd;
   logic       blk_wr;
   logic [2:0] blk_addr;
   logic       int_ack;

   // read data back to the mux
   logic [7:0] ram_q;
   logic [7:0] blk_q;

   soc_bus_ctrl u_bus_ctrl (
      .cpu_clock    (cpu_clock),
      .cpu_reset    (cpu_reset),
      .osd_status   (osd_status),
      .dio_download (dio_download),
      .cpu_addr     (cpu_addr),
      .cpu_mreq     (cpu_mreq),
      .cpu_iorq     (cpu_iorq),
      .cpu_rd       (cpu_rd),
      .cpu_wr       (cpu_wr),
      .cpu_m1       (cpu_m1),
      .cpu_din      (cpu_din),
      .core_reset   (core_reset),
      .ram_rd       (ram_rd),
      .ram_wr       (ram_wr),
      .vram_wr      (vram_wr),
      .blk_rd       (blk_rd),
      .blk_wr       (blk_wr),
      .blk_addr     (blk_addr),
      .int_ack      (int_ack),
      .ram_q        (ram_q),
      .blk_q        (blk_q)
   );

   soc_ram u_ram (
      .cpu_clock    (cpu_clock),
      .ram_rd       (ram_rd),
      .ram_wr       (ram_wr),
      .cpu_addr     (cpu_addr),
      .cpu_dout     (cpu_dout),
      .dio_download (dio_download),
      .dio_write    (dio_write),
      .dio_addr     (dio_addr),
      .dio_data     (dio_data),
      .ram_q        (ram_q)
   );

   video_ram u_video_ram (
      .cpu_clock  (cpu_clock),
      .vram_wr    (vram_wr),
      .cpu_addr   (cpu_addr),
      .cpu_dout   (cpu_dout),
      .video_addr (video_addr),
      .video_q    (video_q)
   );

   // block port and irq run from the stretched reset
   block_io u_block_io (
      .cpu_clock      (cpu_clock),
      .core_reset     (core_reset),
      .blk_rd         (blk_rd),
      .blk_wr         (blk_wr),
      .blk_addr       (blk_addr),
      .cpu_dout       (cpu_dout),
      .blk_q          (blk_q),
      .io_lba         (io_lba),
      .io_rd          (io_rd),
      .io_wr          (io_wr),
      .io_dout        (io_dout),
      .io_ack         (io_ack),
      .io_din         (io_din),
      .io_din_strobe  (io_din_strobe),
      .io_dout_strobe (io_dout_strobe)
   );

   vsync_irq u_vsync_irq (
      .cpu_clock  (cpu_clock),
      .core_reset (core_reset),
      .video_vs   (video_vs),
      .int_ack    (int_ack),
      .cpu_irq    (cpu_irq)
   );

endmodule

// ==== tb_soc.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for soc_core, bus master plus i/o controller model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_soc
   import soc_pkg::*;
;
   localparam logic [31:0] seed = 32'h05be_63f5;
   localparam int wait_limit = 2000;
   localparam int stretch_limit = 1024;
   localparam int irq_limit = 4;
   // pattern tags keep the three data sets apart
   localparam logic [7:0] tag_rom = 8'h3c;
   localparam logic [7:0] tag_rd_sec = 8'h51;
   localparam logic [7:0] tag_wr_sec = 8'ha7;

   logic cpu_clock, cpu_reset, cpu_mreq, cpu_iorq, cpu_rd, cpu_wr, cpu_m1;
   logic [7:0] osd_status, cpu_dout, cpu_din, dio_data, video_q, io_din, io_dout;
   logic [15:0] cpu_addr, dio_addr;
   logic [13:0] video_addr;
   logic [31:0] io_lba;
   logic core_reset, cpu_irq, dio_download, dio_write, video_vs;
   logic io_rd, io_wr, io_ack, io_din_strobe, io_dout_strobe;

   int errors = 0;
   int timeouts = 0;
   logic [31:0] rng = seed;
   // expected read data, pushed with the strobe and popped one cycle later
   logic [7:0] exp_q[$];
   string msg_q[$];
   logic expect_read = 1'b0;
   logic read_seen = 1'b0;
   logic [7:0] sector [0:sector_bytes-1];

   soc_core DUT (.*);

   initial cpu_clock = 1'b0;
   always #2 cpu_clock = ~cpu_clock;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // expected byte for an address, the upper seed half never cancels so x stays nonzero
   function automatic logic [7:0] ref_byte(input logic [15:0] addr, input logic [7:0] tag);
      logic [31:0] x;
      x = xorshift(xorshift(seed ^ {tag, 8'h00, addr}));
      return x[7:0] ^ x[23:16];
   endfunction

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
      if (actual !== expected) begin
         errors++;
         $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      end
   endtask

   task automatic finish_run();
      $display("closing: %0d value errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   endtask

   task automatic timed_out(input string what);
      timeouts++;
      $display("timeout: gave up waiting for %s", what);
      finish_run();
   endtask

   // read data lands on cpu_din one cycle after the strobe
   always @(posedge cpu_clock) begin
      read_seen <= (cpu_mreq || cpu_iorq) && cpu_rd && expect_read;
   end

   always @(negedge cpu_clock) begin
      if (read_seen) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("read checker saw a read with no expected value queued");
         end else begin
            check(32'(cpu_din), 32'(exp_q.pop_front()), msg_q.pop_front());
         end
      end
   end

   // one bus cycle, called on a falling edge, strobes held for one clock
   task automatic bus_cycle(input logic mreq, input logic iorq, input logic rd,
                            input logic wr, input logic m1, input logic [15:0] addr,
                            input logic [7:0] data);
      cpu_mreq = mreq;
      cpu_iorq = iorq;
      cpu_rd = rd;
      cpu_wr = wr;
      cpu_m1 = m1;
      cpu_addr = addr;
      cpu_dout = data;
      @(negedge cpu_clock);
      cpu_mreq = 1'b0;
      cpu_iorq = 1'b0;
      cpu_rd = 1'b0;
      cpu_wr = 1'b0;
      cpu_m1 = 1'b0;
   endtask

   task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
      bus_cycle(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, addr, data);
   endtask

   task automatic io_write(input logic [7:0] port, input logic [7:0] data);
      bus_cycle(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, {8'h00, port}, data);
   endtask

   // unchecked i/o read for polling, value taken after the strobe
   task automatic io_read_value(input logic [7:0] port, output logic [7:0] q);
      bus_cycle(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, {8'h00, port}, 8'h00);
      q = cpu_din;
   endtask

   // mem or i/o read whose data the checker process compares
   task automatic read_expect(input logic mem, input logic [15:0] addr,
                              input logic [7:0] exp, input string what);
      exp_q.push_back(exp);
      msg_q.push_back(what);
      expect_read = 1'b1;
      bus_cycle(mem, !mem, 1'b1, 1'b0, 1'b0, addr, 8'h00);
      expect_read = 1'b0;
   endtask

   // called on the edge where the last reset source drops
   task automatic measure_stretch(input string what);
      int n;
      n = 0;
      while (core_reset && n < stretch_limit) begin
         @(negedge cpu_clock);
         n++;
         check(32'({cpu_irq, io_rd, io_wr}), 32'(0), "outputs idle during reset");
      end
      if (core_reset) begin
         timed_out(what);
      end else begin
         check(32'(n), reset_hold_cycles, what);
      end
   endtask

   task automatic wait_request(input logic want_rd, input string what);
      int n;
      n = 0;
      while ((want_rd ? io_rd : io_wr) !== 1'b1 && n < wait_limit) begin
         @(negedge cpu_clock);
         n++;
      end
      if ((want_rd ? io_rd : io_wr) !== 1'b1) begin
         timed_out(what);
      end
   endtask

   task automatic wait_irq();
      int n;
      n = 0;
      while (cpu_irq !== 1'b1 && n < irq_limit) begin
         @(negedge cpu_clock);
         n++;
      end
      if (cpu_irq !== 1'b1) begin
         timed_out("cpu_irq after a video_vs rising edge");
      end
   endtask

   // busy is bit 0 of reg_cmd
   task automatic wait_idle(input string what);
      int n;
      logic [7:0] status;
      n = 0;
      status = 8'h01;
      while (status[0] && n < wait_limit) begin
         io_read_value({5'd0, reg_cmd}, status);
         n++;
      end
      if (status[0]) begin
         timed_out(what);
      end
   endtask

   task automatic io_ack_pulse();
      io_ack = 1'b1;
      @(negedge cpu_clock);
      io_ack = 1'b0;
   endtask

   initial begin
      logic [15:0] addr;
      logic [7:0] data;
      logic [31:0] lba;
      cpu_reset = 1'b1;
      osd_status = 8'h00;
      cpu_addr = 16'h0000;
      cpu_dout = 8'h00;
      {cpu_mreq, cpu_iorq, cpu_rd, cpu_wr, cpu_m1} = 5'b0;
      dio_download = 1'b0;
      dio_write = 1'b0;
      dio_addr = 16'h0000;
      dio_data = 8'h00;
      video_vs = 1'b0;
      video_addr = 14'h0000;
      io_ack = 1'b0;
      io_din = 8'h00;
      io_din_strobe = 1'b0;
      io_dout_strobe = 1'b0;
      repeat (3) @(negedge cpu_clock);
      check(32'({core_reset, cpu_irq, io_rd, io_wr}), 32'(4'b1000), "outputs in reset");
      check(32'(cpu_din), 32'(0), "cpu_din in reset");
      cpu_reset = 1'b0;
      measure_stretch("core_reset stretch after cpu_reset");

      // menu reset after a finished stretch, then bit 2 in mid stretch
      osd_status = 8'h01;
      @(negedge cpu_clock);
      osd_status = 8'h00;
      repeat (100) @(negedge cpu_clock);
      check(32'(core_reset), 32'(1), "core_reset held after osd reset bit 0");
      osd_status = 8'h04;
      @(negedge cpu_clock);
      osd_status = 8'h00;
      measure_stretch("core_reset stretch after osd reset bit 2");

      // rom download over the full 64 KiB
      dio_download = 1'b1;
      for (int a = 0; a < 65536; a++) begin
         dio_addr = 16'(a);
         dio_data = ref_byte(16'(a), tag_rom);
         dio_write = 1'b1;
         @(negedge cpu_clock);
         check(32'(core_reset), 32'(1), "core_reset during download");
      end
      dio_write = 1'b0;
      dio_download = 1'b0;
      measure_stretch("core_reset stretch after download");
      for (int i = 0; i < 64; i++) begin
         rng = xorshift(rng);
         addr = rng[15:0];
         read_expect(1'b1, addr, ref_byte(addr, tag_rom), $sformatf("ram byte at %h", addr));
      end

      // a15 set lands in ram, a15 clear lands in video ram only
      for (int i = 0; i < 4; i++) begin
         rng = xorshift(rng);
         addr = {1'b1, rng[14:0]};
         data = rng[23:16];
         mem_write(addr, data);
         read_expect(1'b1, addr, data, $sformatf("ram write read-back at %h", addr));
         rng = xorshift(rng);
         addr = {1'b0, rng[14:0]};
         data = rng[23:16];
         mem_write(addr, data);
         video_addr = addr[13:0];
         @(negedge cpu_clock);
         check(32'(video_q), 32'(data), $sformatf("video ram byte for %h", addr));
         read_expect(1'b1, addr, ref_byte(addr, tag_rom), $sformatf("rom kept at %h", addr));
      end

      // sector read, controller streams the sector then acks
      rng = xorshift(rng);
      lba = rng;
      io_write({5'd0, reg_lba0}, lba[7:0]);
      io_write({5'd0, reg_lba1}, lba[15:8]);
      io_write({5'd0, reg_lba2}, lba[23:16]);
      io_write({5'd0, reg_lba3}, lba[31:24]);
      read_expect(1'b0, {13'd0, reg_lba2}, lba[23:16], "lba byte 2 read-back");
      io_write({5'd0, reg_cmd}, cmd_read);
      wait_request(1'b1, "io_rd after cmd_read");
      check(io_lba, lba, "io_lba during sector read");
      check(32'(io_wr), 32'(0), "io_wr during sector read");
      read_expect(1'b0, {13'd0, reg_cmd}, 8'h01, "busy during sector read");
      for (int i = 0; i < sector_bytes; i++) begin
         io_din = ref_byte(16'(i), tag_rd_sec);
         io_din_strobe = 1'b1;
         @(negedge cpu_clock);
      end
      io_din_strobe = 1'b0;
      io_ack_pulse();
      wait_idle("busy to clear after sector read");
      check(32'({io_rd, io_wr}), 32'(0), "requests after read ack");
      for (int i = 0; i < sector_bytes; i++) begin
         read_expect(1'b0, {13'd0, reg_data}, ref_byte(16'(i), tag_rd_sec),
                     $sformatf("sector read byte %0d", i));
      end

      // sector write, controller pulls every byte through io_dout
      for (int i = 0; i < sector_bytes; i++) begin
         io_write({5'd0, reg_data}, ref_byte(16'(i), tag_wr_sec));
      end
      io_write({5'd0, reg_cmd}, cmd_write);
      wait_request(1'b0, "io_wr after cmd_write");
      io_write({5'd0, reg_cmd}, cmd_read);
      check(32'({io_rd, io_wr}), 32'(2'b01), "command while busy");
      for (int i = 0; i < sector_bytes; i++) begin
         sector[i] = io_dout;
         io_dout_strobe = 1'b1;
         @(negedge cpu_clock);
      end
      io_dout_strobe = 1'b0;
      for (int i = 0; i < sector_bytes; i++) begin
         check(32'(sector[i]), 32'(ref_byte(16'(i), tag_wr_sec)),
               $sformatf("sector write byte %0d", i));
      end
      io_ack_pulse();
      check(32'(io_wr), 32'(0), "io_wr after write ack");
      wait_idle("busy to clear after sector write");

      // vsync interrupt and acknowledge
      check(32'(cpu_irq), 32'(0), "cpu_irq before vsync");
      video_vs = 1'b1;
      wait_irq();
      bus_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 16'h0038, 8'h00);
      check(32'(cpu_irq), 32'(0), "cpu_irq after acknowledge");
      video_vs = 1'b0;
      // nonzero byte on cpu_din first, the unmapped read has to clear it
      mem_write(16'h8000, 8'hff);
      read_expect(1'b1, 16'h8000, 8'hff, "ram byte before unmapped read");
      read_expect(1'b0, 16'h0008, 8'h00, "unmapped i/o port 8");
      @(negedge cpu_clock);
      check(32'(exp_q.size()), 32'(0), "expected reads left unchecked");
      finish_run();
   end

endmodule

// ==== files.f ====
soc_pkg.sv
soc_bus_ctrl.sv
soc_ram.sv
video_ram.sv
block_io.sv
vsync_irq.sv
soc_core.sv
tb_soc.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   -f files.f --top-module tb_soc -o tb_soc

# keep the output in memory so the check below needs no log file
out=$(./obj_dir/tb_soc || true)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "Simulation PASSED"
